// ==== div_asserts.sv ====
/*
 * Divide unit protocol assertions
 * Bound into div_unit for queue overflow, writeback pulse and divider latency
 */
`timescale 1ns/100ps

module div_asserts #(
    parameter int WIDTH = 32
) (
    input logic clk,
    input logic rst,
    input logic push,
    input logic full,
    input logic start,
    input logic complete,
    input logic wb_valid
);

    // Failure tally, read by the testbench
    int fail_count = 0;

    // Issuer must respect ready
    no_push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else begin
            $error("push into a full request queue");
            fail_count++;
        end

    // Writeback strobe is a single cycle
    wb_single_cycle: assert property (@(posedge clk) disable iff (rst) wb_valid |=> !wb_valid)
        else begin
            $error("wb_valid held longer than one cycle");
            fail_count++;
        end

    // Fixed divider latency
    complete_after_start: assert property (
        @(posedge clk) disable iff (rst) start |-> ##(WIDTH+1) complete)
        else begin
            $error("divider completion not WIDTH+1 cycles after start");
            fail_count++;
        end

endmodule

// ==== div_checker.sv ====
/*
 * Divide unit result checker
 * Models RV32M results in issue order and compares each writeback, ready and latency
 */
`timescale 1ns/100ps

module div_checker import div_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_valid,
    input  logic     issue_ready,
    input  div_req_t issue_req,
    input  logic     wb_valid,
    input  div_wb_t  wb,
    output int       errors,
    output int       pending,
    output int       checked
);

    // Expected results, oldest first
    div_wb_t exp_q [$];
    // Due cycle per result or -1 when the unit was busy at issue
    int      due_q [$];
    int      cycle;

    // Expected rd by the RV32M rules
    function automatic logic [XLEN-1:0] model_rd(input logic [XLEN-1:0] rs1,
                                                 input logic [XLEN-1:0] rs2,
                                                 input div_op_e op);
        logic                   ovf;
        logic signed [XLEN-1:0] s1;
        logic signed [XLEN-1:0] s2;
        logic        [XLEN-1:0] rd;
        ovf = (rs1 == {1'b1, {(XLEN-1){1'b0}}}) && (rs2 == '1);
        s1  = rs1;
        s2  = rs2;
        // Zero divisor and signed overflow before any arithmetic
        if (rs2 == '0) begin
            rd = (op == OP_DIV || op == OP_DIVU) ? '1 : rs1;
        end else if (ovf && op == OP_DIV) begin
            rd = rs1;
        end else if (ovf && op == OP_REM) begin
            rd = '0;
        end else begin
            case (op)
                OP_DIV:  rd = s1 / s2;
                OP_DIVU: rd = rs1 / rs2;
                OP_REM:  rd = s1 % s2;
                default: rd = rs1 % rs2;
            endcase
        end
        return rd;
    endfunction

    always @(posedge clk) begin
        div_wb_t want;
        int      due;
        if (rst) begin
            exp_q.delete();
            due_q.delete();
            cycle   = 0;
            errors  = 0;
            checked = 0;
        end else begin
            cycle++;
            // Ready low exactly while QUEUE_DEPTH requests are held
            if (issue_ready !== (exp_q.size() < QUEUE_DEPTH)) begin
                $display("mismatch at %0t: issue_ready expected %b got %b",
                         $time, exp_q.size() < QUEUE_DEPTH, issue_ready);
                errors++;
            end
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    $display("writeback at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    due  = due_q.pop_front();
                    checked++;
                    if (wb.rd !== want.rd) begin
                        $display("mismatch at %0t: wb.rd expected %h got %h",
                                 $time, want.rd, wb.rd);
                        errors++;
                    end
                    if (wb.id !== want.id) begin
                        $display("mismatch at %0t: wb.id expected %h got %h",
                                 $time, want.id, wb.id);
                        errors++;
                    end
                    if (due >= 0 && cycle != due) begin
                        $display("mismatch at %0t: wb_valid cycle expected %0d got %0d",
                                 $time, due, cycle);
                        errors++;
                    end
                end
            end
            // Pop happens above so an issue on the same edge sees an idle unit
            if (issue_valid) begin
                due     = (exp_q.size() == 0) ? cycle + XLEN + 2 : -1;
                want.rd = model_rd(issue_req.rs1, issue_req.rs2, issue_req.op);
                want.id = issue_req.id;
                exp_q.push_back(want);
                due_q.push_back(due);
            end
        end
        pending = exp_q.size();
    end

endmodule

// ==== div_pkg.sv ====
/*
 * Divide unit shared types
 * Operand width, id width, operation codes and request and writeback structs
 */
package div_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths

    // Operand and result width
    localparam int XLEN = 32;

    // Instruction id width
    localparam int DIV_ID_W = 4;

    //////////////////////////////////////////////////////////////////////
    // Operation codes

    // Bit 0 selects unsigned, bit 1 selects remainder
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

    //////////////////////////////////////////////////////////////////////
    // Request and writeback payloads

    // Issue request, 70 bits
    typedef struct packed {
        logic [XLEN-1:0]     rs1;
        logic [XLEN-1:0]     rs2;
        div_op_e             op;
        logic [DIV_ID_W-1:0] id;
    } div_req_t;

    // Writeback result with its id, 36 bits
    typedef struct packed {
        logic [XLEN-1:0]     rd;
        logic [DIV_ID_W-1:0] id;
    } div_wb_t;

endpackage

// ==== div_queue.sv ====
/*
 * Divide request queue
 * In-order circular buffer with a combinational head and full and valid flags
 */
`timescale 1ns/100ps

module div_queue import div_pkg::*; #(
    parameter int DEPTH = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  div_req_t data_in,
    output div_req_t data_out,
    output logic     valid,
    output logic     full
);

    // Pointer width kept at one bit or more for a single entry
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    div_req_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Push into a full queue is dropped
    assign wr_en = push & ~full;
    assign rd_en = pop & valid;

    // Storage, no reset on entries
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on push with pop
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry and flags
    assign data_out = mem[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

endmodule

// ==== div_radix2_core.sv ====
/*
 * Radix-2 restoring divider
 * Unsigned, one quotient bit per cycle, completion pulse WIDTH+1 cycles after start
 */
`timescale 1ns/100ps

module div_radix2_core #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] q,
    output logic [WIDTH-1:0] r,
    output logic             b_zero,
    output logic             complete
);

    // Dividend shifts out the top while quotient bits shift in the bottom
    logic [WIDTH-1:0] aq;
    logic [WIDTH-1:0] divisor;
    logic [WIDTH-1:0] rem;

    // One-hot step counter, zero when idle
    logic [WIDTH-1:0] step;

    // Trial subtraction
    logic [WIDTH:0]   rem_shift;
    logic [WIDTH:0]   diff;
    logic             q_bit;

    //////////////////////////////////////////////////////////////////////
    // Trial subtraction

    // Next dividend bit enters the partial remainder
    assign rem_shift = {rem, aq[WIDTH-1]};
    assign diff      = rem_shift - {1'b0, divisor};

    // Borrow out means restore
    assign q_bit = ~diff[WIDTH];

    //////////////////////////////////////////////////////////////////////
    // Datapath

    always_ff @(posedge clk) begin
        if (start) begin
            aq      <= a;
            divisor <= b;
            rem     <= '0;
            // Zero divisor never borrows, so q ends all ones and r holds a
            b_zero  <= (b == '0);
        end else if (step != '0) begin
            aq  <= {aq[WIDTH-2:0], q_bit};
            rem <= q_bit ? diff[WIDTH-1:0] : rem_shift[WIDTH-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Control

    // WIDTH iteration edges after the start edge
    always_ff @(posedge clk) begin
        if (rst) begin
            step     <= '0;
            complete <= 1'b0;
        end else begin
            if (start) begin
                step <= WIDTH'(1);
            end else begin
                step <= step << 1;
            end
            // Last iteration edge raises the pulse for one cycle
            complete <= step[WIDTH-1] & ~start;
        end
    end

    assign q = aq;
    assign r = rem;

endmodule

// ==== div_tb.sv ====
/*
 * Divide unit testbench
 * Table and xorshift requests into the top level, checker compares every writeback
 */
`timescale 1ns/100ps

module div_tb import div_pkg::*; ();

    localparam int QUEUE_DEPTH = 2;
    localparam int N_VEC       = 22;
    localparam int N_RANDOM    = 40;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    // One stimulus entry, gap is idle cycles after the strobe
    typedef struct packed {
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        div_op_e         op;
        logic [7:0]      gap;
    } vec_t;

    logic                clk;
    logic                rst;
    logic                issue_valid;
    div_req_t            issue_req;
    logic                issue_ready;
    logic                wb_valid;
    div_wb_t             wb;

    // Checker results
    int                  chk_errors;
    int                  pending;
    int                  checked;

    // Run bookkeeping
    int                  run_errors;
    int                  issued;
    logic [DIV_ID_W-1:0] next_id;
    logic [31:0]         rng;

    vec_t vectors [N_VEC] = '{
        // Mixed signs, quotient then remainder
        '{32'd20,        32'd6,         OP_DIV,  8'd40},
        '{32'hFFFF_FFEC, 32'd6,         OP_DIV,  8'd0},
        '{32'd20,        32'hFFFF_FFFA, OP_DIV,  8'd0},
        '{32'hFFFF_FFEC, 32'hFFFF_FFFA, OP_DIV,  8'd0},
        '{32'd20,        32'd6,         OP_REM,  8'd0},
        '{32'hFFFF_FFEC, 32'd6,         OP_REM,  8'd0},
        '{32'd20,        32'hFFFF_FFFA, OP_REM,  8'd0},
        '{32'hFFFF_FFEC, 32'hFFFF_FFFA, OP_REM,  8'd40},
        // Unsigned view of negative patterns
        '{32'hFFFF_FFEC, 32'd6,         OP_DIVU, 8'd0},
        '{32'hFFFF_FFEC, 32'd6,         OP_REMU, 8'd0},
        '{32'hDEAD_BEEF, 32'h0001_0000, OP_DIVU, 8'd0},
        '{32'hDEAD_BEEF, 32'h0001_0000, OP_REMU, 8'd40},
        // Zero divisor
        '{32'd1234,      32'd0,         OP_DIV,  8'd0},
        '{32'hFFFF_0000, 32'd0,         OP_DIVU, 8'd0},
        '{32'hFFFF_FFF9, 32'd0,         OP_REM,  8'd0},
        '{32'h89AB_CDEF, 32'd0,         OP_REMU, 8'd40},
        // Most negative over minus one
        '{32'h8000_0000, 32'hFFFF_FFFF, OP_DIV,  8'd0},
        '{32'h8000_0000, 32'hFFFF_FFFF, OP_REM,  8'd0},
        '{32'h8000_0000, 32'hFFFF_FFFF, OP_DIVU, 8'd0},
        '{32'h8000_0000, 32'hFFFF_FFFF, OP_REMU, 8'd40},
        '{32'd7,         32'd1,         OP_DIV,  8'd0},
        '{32'd0,         32'd5,         OP_REMU, 8'd3}
    };

    //////////////////////////////////////////////////////////////////////
    // Clock, DUT, checker, assertions

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    div_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .issue_valid(issue_valid),
        .issue_req  (issue_req),
        .issue_ready(issue_ready),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

    div_checker #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_chk (
        .clk        (clk),
        .rst        (rst),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .issue_req  (issue_req),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .errors     (chk_errors),
        .pending    (pending),
        .checked    (checked)
    );

    bind div_unit div_asserts #(
        .WIDTH(XLEN)
    ) u_asserts (
        .clk     (clk),
        .rst     (rst),
        .push    (issue_valid),
        .full    (q_full),
        .start   (start),
        .complete(complete),
        .wb_valid(wb_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic send(input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                        input div_op_e op, input int gap);
        int n;
        n = 0;
        while (!issue_ready && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!issue_ready) begin
            $display("timeout: issue_ready stayed low for %0d cycles at %0t", WAIT_LIMIT, $time);
            run_errors++;
        end else begin
            issue_req.rs1 = rs1;
            issue_req.rs2 = rs2;
            issue_req.op  = op;
            issue_req.id  = next_id;
            issue_valid   = 1'b1;
            @(posedge clk);
            #1;
            issue_valid = 1'b0;
            next_id++;
            issued++;
            for (int i = 0; i < gap; i++) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        div_op_e         op;
        int              gap;
        int              n;
        issue_valid = 1'b0;
        issue_req   = '0;
        rst         = 1'b1;
        run_errors  = 0;
        issued      = 0;
        next_id     = '0;
        rng         = 32'd87;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < N_VEC; i++) begin
            if (run_errors == 0) begin
                send(vectors[i].rs1, vectors[i].rs2, vectors[i].op, int'(vectors[i].gap));
            end
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            rng = xorshift32(rng);
            a   = rng;
            rng = xorshift32(rng);
            b   = rng;
            // Small divisors now and then for long quotients
            if (b[31:30] == 2'b00) begin
                b = b >> 20;
            end
            rng = xorshift32(rng);
            op  = div_op_e'(rng[1:0]);
            gap = (rng[7:4] == 4'd0) ? 40 : int'(rng[2]);
            if (run_errors == 0) begin
                send(a, b, op, gap);
            end
        end

        // Drain outstanding results
        n = 0;
        while (pending != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("timeout: %0d results still outstanding at %0t", pending, $time);
            run_errors++;
        end
        if (checked != issued) begin
            $display("lost results: %0d issued, %0d written back", issued, checked);
            run_errors++;
        end

        $display("errors: %0d checker, %0d assertion, %0d run; %0d results checked",
                 chk_errors, u_dut.u_unit.u_asserts.fail_count, run_errors, checked);
        if (chk_errors == 0 && u_dut.u_unit.u_asserts.fail_count == 0 && run_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== div_top.sv ====
/*
 * Divide subsystem top level
 * Sets the queue depth and exposes issue and writeback ports
 */
`timescale 1ns/100ps

module div_top import div_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic     clk,
    input  logic     rst,
    // Issue side
    input  logic     issue_valid,
    input  div_req_t issue_req,
    output logic     issue_ready,
    // Writeback side, always accepted
    output logic     wb_valid,
    output div_wb_t  wb
);

    div_unit #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_unit (
        .clk        (clk),
        .rst        (rst),
        .issue_valid(issue_valid),
        .issue_req  (issue_req),
        .issue_ready(issue_ready),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

endmodule

// ==== div_unit.sv ====
/*
 * RV32M divide unit
 * Queues requests, converts to magnitudes, runs the divider and forms writeback
 */
`timescale 1ns/100ps

module div_unit import div_pkg::*; #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_valid,
    input  div_req_t issue_req,
    output logic     issue_ready,
    output logic     wb_valid,
    output div_wb_t  wb
);

    // Queue head and flags
    div_req_t        head;
    logic            head_valid;
    logic            q_full;

    // Divider control
    logic            start;
    logic            busy;
    logic            complete;
    logic            done;

    // Sign handling
    logic            signed_op;
    logic            dividend_neg;
    logic            divisor_neg;
    logic            quotient_neg;
    logic            remainder_neg;
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;

    // Divider results
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic            b_zero;

    // Result selection
    logic            negate;
    logic [XLEN-1:0] sel;
    logic [XLEN-1:0] result;

    //////////////////////////////////////////////////////////////////////
    // Request queue

    div_queue #(
        .DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk     (clk),
        .rst     (rst),
        .push    (issue_valid),
        .pop     (done),
        .data_in (issue_req),
        .data_out(head),
        .valid   (head_valid),
        .full    (q_full)
    );

    // Entry being divided stays queued, so full covers it too
    assign issue_ready = ~q_full;

    //////////////////////////////////////////////////////////////////////
    // Divider control

    assign start = head_valid & ~busy;
    assign done  = complete;

    // Busy from start until the completion pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (complete) begin
            busy <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operand signs and magnitudes

    assign signed_op     = ~head.op[0];
    assign dividend_neg  = signed_op & head.rs1[XLEN-1];
    assign divisor_neg   = signed_op & head.rs2[XLEN-1];
    assign quotient_neg  = signed_op & (head.rs1[XLEN-1] ^ head.rs2[XLEN-1]);
    // Remainder follows the dividend sign
    assign remainder_neg = dividend_neg;

    // Two's complement negate when negative
    assign mag_a = ({XLEN{dividend_neg}} ^ head.rs1) + XLEN'(dividend_neg);
    assign mag_b = ({XLEN{divisor_neg}} ^ head.rs2) + XLEN'(divisor_neg);

    div_radix2_core #(
        .WIDTH(XLEN)
    ) u_core (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .a       (mag_a),
        .b       (mag_b),
        .q       (quotient),
        .r       (remainder),
        .b_zero  (b_zero),
        .complete(complete)
    );

    //////////////////////////////////////////////////////////////////////
    // Writeback

    // Divide by zero keeps the all ones quotient
    assign negate = head.op[1] ? remainder_neg : (quotient_neg & ~b_zero);
    assign sel    = head.op[1] ? remainder : quotient;
    assign result = ({XLEN{negate}} ^ sel) + XLEN'(negate);

    assign wb_valid = done;
    assign wb.rd    = result;
    assign wb.id    = head.id;

endmodule

// ==== files.f ====
div_pkg.sv
div_queue.sv
div_radix2_core.sv
div_unit.sv
div_top.sv
div_asserts.sv
div_checker.sv
div_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the divide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module div_tb -f files.f -o div_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/div_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
